// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sdr_baseband
FILELIST  ?= sdr_baseband.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/adc_capture.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module adc_capture (
    input  logic               clk,
    input  logic               reset_i,
    input  sdr_pkg::adc_word_t adc_a_i,
    input  sdr_pkg::adc_word_t adc_b_i,
    input  sdr_pkg::sample_t   dds_sample_i,
    output sdr_pkg::stage_t    stage_o,
    output logic [1:0]         ovr_o
);
    import sdr_pkg::*;

    // Offset binary -> two's complement, just the MSB flipped
    function automatic sample_t to_signed(input logic [`SDR_SAMPLE_W-1:0] raw);
        logic [`SDR_SAMPLE_W-1:0] flipped;
        flipped = {~raw[`SDR_SAMPLE_W-1], raw[`SDR_SAMPLE_W-2:0]};
        return sample_t'(flipped);
    endfunction

    //////////////////////////////
    // Stage 1 sample register
    //////////////////////////////

    // Samples move every clock, no valid
    always_ff @(posedge clk) begin
        stage_o.ch_a <= to_signed(adc_a_i.data);
        stage_o.ch_b <= to_signed(adc_b_i.data);
        stage_o.dds  <= dds_sample_i; // DDS rides along to keep alignment
    end

    //////////////////////////////
    // Overrange events
    //////////////////////////////

    // One pulse per sampled overrange, bit 0 is channel A
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ovr_o <= 2'b00;
        end else begin
            ovr_o <= {adc_b_i.ovr, adc_a_i.ovr};
        end
    end

endmodule

// ==== hdl/apb_regs.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module apb_regs (
    input  logic                  clk,
    input  logic                  reset_i,
    input  sdr_pkg::apb_req_t     apb_req_i,
    output logic [`SDR_APB_W-1:0] prdata_o,
    input  logic [1:0]            ovr_i,
    output sdr_pkg::dac_cfg_u     dac_a_cfg_o,
    output sdr_pkg::dac_cfg_u     dac_b_cfg_o,
    output sdr_pkg::dds_cfg_t     dds_cfg_o,
    output logic [15:0]           adc_ioexp_o,
    output logic [15:0]           dac_ioexp_o
);
    import sdr_pkg::*;

    logic [3:0] page;       // paddr[15:12]
    logic       wr_en;      // Access-phase write
    logic [1:0] ovr_clr;    // Write-one-to-clear mask
    logic [1:0] ovr_q;      // Sticky bits
    logic [1:0] ovr_status; // Bit 0 is channel A
    dac_cfg_t   cfg_a;
    dac_cfg_t   cfg_b;

    assign page  = apb_req_i.paddr[15:12];
    assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

    //////////////////////////////
    // Configuration registers
    //////////////////////////////

    // Writes land on the edge that ends the access cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dac_a_cfg_o <= '0; // Silence, amps off
            dac_b_cfg_o <= '0;
            dds_cfg_o   <= '0; // DDS off
        end else if (wr_en) begin
            case (page)
                `SDR_PAGE_DACA: dac_a_cfg_o.word <= apb_req_i.pwdata;
                `SDR_PAGE_DACB: dac_b_cfg_o.word <= apb_req_i.pwdata;
                `SDR_PAGE_DDS:  dds_cfg_o        <= dds_cfg_t'(apb_req_i.pwdata);
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // Overrange status
    //////////////////////////////

    assign ovr_clr = (wr_en && page == `SDR_PAGE_ADC) ? apb_req_i.pwdata[1:0] : 2'b00;

    // New event beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ovr_q <= 2'b00;
        end else begin
            ovr_q <= (ovr_q & ~ovr_clr) | ovr_i;
        end
    end

    // Pulse shows up right away, sticky copy holds it afterwards
    assign ovr_status = ovr_q | ovr_i;

    // Read mux, unused pages read zero
    always_comb begin
        case (page)
            `SDR_PAGE_ADC:  prdata_o = {{(`SDR_APB_W-2){1'b0}}, ovr_status};
            `SDR_PAGE_DACA: prdata_o = dac_a_cfg_o.word;
            `SDR_PAGE_DACB: prdata_o = dac_b_cfg_o.word;
            `SDR_PAGE_DDS:  prdata_o = dds_cfg_o;
            default:        prdata_o = '0;
        endcase
    end

    //////////////////////////////
    // IO expander words
    //////////////////////////////

    assign cfg_a = dac_a_cfg_o.fld; // Also sets input A front end
    assign cfg_b = dac_b_cfg_o.fld;

    // ADC board, LEDs active low, red forced during overrange
    assign adc_ioexp_o = {
        1'b0,                                  // LED common B
        ~(ovr_status[0] | cfg_a.led[2]),       // Red A
        ~(ovr_status[1] | cfg_b.led[2]),       // Red B
        1'b0,                                  // LED common A
        ~(~ovr_status[1] & cfg_b.led[1]),
        ~(~ovr_status[1] & cfg_b.led[0]),
        ~(~ovr_status[0] & cfg_a.led[1]),
        ~(~ovr_status[0] & cfg_a.led[0]),
        1'b0,
        cfg_a.amp_en,
        ~cfg_a.att[1],                         // Attenuators active low
        ~cfg_a.att[0],
        1'b0,
        cfg_b.amp_en,
        ~cfg_b.att[1],
        ~cfg_b.att[0]
    };

    // DAC board, port 1 LEDs then port 0 front end
    assign dac_ioexp_o = {
        ~cfg_a.led[2],
        1'b0,                                  // LED common B
        ~cfg_b.led[2],
        1'b0,                                  // LED common A
        ~cfg_a.led[1],
        ~cfg_a.led[0],
        ~cfg_b.led[0],
        ~cfg_b.led[1],
        ~cfg_b.att[0],
        ~cfg_b.att[1],
        cfg_b.amp_en,
        1'b0,
        1'b0,                                  // DAC clock enable, always on
        ~cfg_a.att[0],
        ~cfg_a.att[1],
        cfg_a.amp_en
    };

endmodule

// ==== hdl/dac_source_mux.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module dac_source_mux (
    input  logic                     clk,
    input  logic                     reset_i,
    input  sdr_pkg::stage_t          stage_i,
    input  sdr_pkg::dac_cfg_u        dac_a_cfg_i,
    input  sdr_pkg::dac_cfg_u        dac_b_cfg_i,
    output logic [`SDR_SAMPLE_W-1:0] dac_a_o,
    output logic [`SDR_SAMPLE_W-1:0] dac_b_o
);
    import sdr_pkg::*;

    // Offset-binary zero for the converter
    localparam logic [`SDR_SAMPLE_W-1:0] DAC_MID = 1 << (`SDR_SAMPLE_W - 1);

    // Source pick and conversion back to offset binary
    function automatic logic [`SDR_SAMPLE_W-1:0] pick(input dac_cfg_u cfg, input stage_t st);
        sample_t s;
        case (cfg.fld.src)
            SRC_INA: s = st.ch_a;
            SRC_INB: s = st.ch_b;
            SRC_DDS: s = st.dds;
            default: s = '0; // Silence
        endcase
        return {~s[`SDR_SAMPLE_W-1], s[`SDR_SAMPLE_W-2:0]};
    endfunction

    //////////////////////////////
    // Stage 2 output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            dac_a_o <= DAC_MID;
            dac_b_o <= DAC_MID;
        end else begin
            dac_a_o <= pick(dac_a_cfg_i, stage_i);
            dac_b_o <= pick(dac_b_cfg_i, stage_i);
        end
    end

endmodule

// ==== hdl/dds_gen.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module dds_gen (
    input  logic              clk,
    input  logic              reset_i,
    input  sdr_pkg::dds_cfg_t dds_cfg_i,
    output sdr_pkg::sample_t  sample_o
);
    import sdr_pkg::*;

    localparam int TOP = `SDR_PHASE_W - 1; // Half-cycle bit

    logic [`SDR_PHASE_W-1:0]  phase_q;
    logic [`SDR_SAMPLE_W-1:0] ramp;     // Rising then falling, unsigned
    logic [`SDR_SAMPLE_W-1:0] tri_wave;

    //////////////////////////////
    // Phase accumulator
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase_q <= '0;
        end else if (dds_cfg_i.en) begin
            phase_q <= phase_q + `SDR_PHASE_W'(dds_cfg_i.step); // Wraps naturally
        end else begin
            phase_q <= '0; // Disabled, restart from zero
        end
    end

    //////////////////////////////
    // Triangle shaper
    //////////////////////////////

    // Bits below the half-cycle bit form the ramp
    always_comb begin
        if (phase_q[TOP]) begin
            ramp = ~phase_q[TOP-1 -: `SDR_SAMPLE_W]; // Second half, ramp down
        end else begin
            ramp = phase_q[TOP-1 -: `SDR_SAMPLE_W];
        end
        // Centre on zero, -128 .. 127
        tri_wave = {~ramp[`SDR_SAMPLE_W-1], ramp[`SDR_SAMPLE_W-2:0]};
    end

    // Registered by the capture stage
    assign sample_o = sample_t'(tri_wave);

endmodule

// ==== hdl/sdr_baseband_top.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module sdr_baseband_top (
    input  logic                     clk,
    input  logic                     reset_i,
    input  sdr_pkg::apb_req_t        apb_req_i,
    output logic [`SDR_APB_W-1:0]    prdata_o,
    input  sdr_pkg::adc_word_t       adc_a_i,
    input  sdr_pkg::adc_word_t       adc_b_i,
    output logic [`SDR_SAMPLE_W-1:0] dac_a_o,
    output logic [`SDR_SAMPLE_W-1:0] dac_b_o,
    output logic [15:0]              adc_ioexp_o,
    output logic [15:0]              dac_ioexp_o
);
    import sdr_pkg::*;

    stage_t     stage;      // Capture -> mux
    sample_t    dds_sample; // Unregistered triangle
    logic [1:0] ovr;        // Overrange events
    dac_cfg_u   dac_a_cfg;
    dac_cfg_u   dac_b_cfg;
    dds_cfg_t   dds_cfg;

    //////////////////////////////
    // Sample pipeline
    //////////////////////////////

    adc_capture u_adc_capture (
        .clk          (clk),
        .reset_i      (reset_i),
        .adc_a_i      (adc_a_i),
        .adc_b_i      (adc_b_i),
        .dds_sample_i (dds_sample),
        .stage_o      (stage),
        .ovr_o        (ovr)
    );

    dds_gen u_dds_gen (
        .clk       (clk),
        .reset_i   (reset_i),
        .dds_cfg_i (dds_cfg),
        .sample_o  (dds_sample)
    );

    dac_source_mux u_dac_source_mux (
        .clk         (clk),
        .reset_i     (reset_i),
        .stage_i     (stage),
        .dac_a_cfg_i (dac_a_cfg),
        .dac_b_cfg_i (dac_b_cfg),
        .dac_a_o     (dac_a_o),
        .dac_b_o     (dac_b_o)
    );

    // Host registers
    apb_regs u_apb_regs (
        .clk         (clk),
        .reset_i     (reset_i),
        .apb_req_i   (apb_req_i),
        .prdata_o    (prdata_o),
        .ovr_i       (ovr),
        .dac_a_cfg_o (dac_a_cfg),
        .dac_b_cfg_o (dac_b_cfg),
        .dds_cfg_o   (dds_cfg),
        .adc_ioexp_o (adc_ioexp_o),
        .dac_ioexp_o (dac_ioexp_o)
    );

endmodule

// ==== hdl/sdr_config.svh ====
`ifndef SDR_CONFIG_SVH
`define SDR_CONFIG_SVH

// Datapath widths
`define SDR_SAMPLE_W 8  // ADC and DAC sample
`define SDR_PHASE_W  32 // DDS phase accumulator
`define SDR_APB_W    32 // Host bus data and address

//////////////////////////////
// Register pages, paddr[15:12]
//////////////////////////////

`define SDR_PAGE_ADC  4'h0 // Overrange status, write one to clear
`define SDR_PAGE_DACA 4'h2 // DAC A configuration
`define SDR_PAGE_DACB 4'h3 // DAC B configuration
`define SDR_PAGE_DDS  4'h5 // DDS enable and step

//////////////////////////////
// DAC source codes
//////////////////////////////

`define SDR_SRC_ZERO 2'd0 // Silence
`define SDR_SRC_INA  2'd1
`define SDR_SRC_INB  2'd2
`define SDR_SRC_DDS  2'd3

`endif

// ==== hdl/sdr_pkg.sv ====
`include "sdr_config.svh"

package sdr_pkg;

    // Signed sample inside the fabric
    typedef logic signed [`SDR_SAMPLE_W-1:0] sample_t;

    // Raw converter word, offset binary plus overrange flag
    typedef struct packed {
        logic [`SDR_SAMPLE_W-1:0] data;
        logic                     ovr;
    } adc_word_t;

    typedef enum logic [1:0] {
        SRC_ZERO = `SDR_SRC_ZERO,
        SRC_INA  = `SDR_SRC_INA,
        SRC_INB  = `SDR_SRC_INB,
        SRC_DDS  = `SDR_SRC_DDS
    } src_sel_t;

    // DAC channel configuration, source in the low bits
    typedef struct packed {
        logic [23:0] pad;    // Unused, kept for readback
        logic [2:0]  led;    // Blue, green, red
        logic        amp_en;
        logic [1:0]  att;
        src_sel_t    src;
    } dac_cfg_t;

    // Same word as the bus sees it and as the datapath decodes it
    typedef union packed {
        logic [`SDR_APB_W-1:0] word;
        dac_cfg_t              fld;
    } dac_cfg_u;

    typedef struct packed {
        logic        en;
        logic [30:0] step; // Phase increment per clock
    } dds_cfg_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`SDR_APB_W-1:0] paddr;
        logic [`SDR_APB_W-1:0] pwdata;
    } apb_req_t;

    // First to second stage
    typedef struct packed {
        sample_t ch_a;
        sample_t ch_b;
        sample_t dds;
    } stage_t;

endpackage

// ==== sdr_baseband.f ====
+incdir+hdl
hdl/sdr_pkg.sv
hdl/adc_capture.sv
hdl/dds_gen.sv
hdl/dac_source_mux.sv
hdl/apb_regs.sv
hdl/sdr_baseband_top.sv
verification/sdr_baseband_chk.sv
verification/tb_sdr_baseband.sv

// ==== verification/sdr_baseband_chk.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module sdr_baseband_chk (
    input logic                     clk,
    input logic                     reset_i,
    input sdr_pkg::apb_req_t        apb_req_i,
    input sdr_pkg::adc_word_t       adc_a_i,
    input sdr_pkg::adc_word_t       adc_b_i,
    input logic [`SDR_SAMPLE_W-1:0] dac_a_i,
    input logic [`SDR_SAMPLE_W-1:0] dac_b_i,
    input logic [15:0]              adc_ioexp_i
);

    int fail_cnt = 0; // Assertion failures so far

    // Offset-binary zero on both DACs once reset has been seen
    dac_mid_after_reset: assert property (@(posedge clk)
        reset_i |=> (dac_a_i == 8'd128 && dac_b_i == 8'd128))
        else begin
            $error("DAC outputs not at midscale after reset");
            fail_cnt++;
        end

    // APB access phase only inside a selected transfer
    penable_needs_psel: assert property (@(posedge clk) apb_req_i.penable |-> apb_req_i.psel)
        else begin
            $error("penable high without psel");
            fail_cnt++;
        end

    // Active-low red LED on bit 14 for channel A and bit 13 for B
    ovr_a_sets_status: assert property (@(posedge clk) disable iff (reset_i)
        adc_a_i.ovr |=> !adc_ioexp_i[14])
        else begin
            $error("Channel A overrange did not set its status");
            fail_cnt++;
        end

    ovr_b_sets_status: assert property (@(posedge clk) disable iff (reset_i)
        adc_b_i.ovr |=> !adc_ioexp_i[13])
        else begin
            $error("Channel B overrange did not set its status");
            fail_cnt++;
        end

endmodule

bind sdr_baseband_top sdr_baseband_chk u_sdr_baseband_chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .apb_req_i   (apb_req_i),
    .adc_a_i     (adc_a_i),
    .adc_b_i     (adc_b_i),
    .dac_a_i     (dac_a_o),
    .dac_b_i     (dac_b_o),
    .adc_ioexp_i (adc_ioexp_o)
);

// ==== verification/tb_sdr_baseband.sv ====
`timescale 1ns/100ps
`include "sdr_config.svh"

module tb_sdr_baseband;
    import sdr_pkg::*;

    // Cycles per test in run order (reset check, readback, samples, overrange, DDS)
    localparam int TEST_CYC  = 33 + 128 + 216 + 168 + 110;
    localparam int RESET_CYC = 10;
    localparam int LIMIT     = 2 * TEST_CYC + RESET_CYC;

    logic                     clk;
    logic                     reset_i;
    apb_req_t                 apb_req;
    adc_word_t                adc_a;
    adc_word_t                adc_b;
    logic [`SDR_APB_W-1:0]    prdata;
    logic [`SDR_SAMPLE_W-1:0] dac_a;
    logic [`SDR_SAMPLE_W-1:0] dac_b;
    logic [15:0]              adc_ioexp;
    logic [15:0]              dac_ioexp;

    logic [31:0] lfsr_q;
    int          cyc_cnt = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          t_err0;   // Counts at test start
    int          t_chk0;

    // Model state as of the last rising edge
    dac_cfg_u    m_cfg_a;
    dac_cfg_u    m_cfg_b;
    dds_cfg_t    m_dds;
    logic [31:0] m_phase;
    sample_t     m_st_a;   // Capture stage
    sample_t     m_st_b;
    sample_t     m_st_dds;
    logic [7:0]  m_dac_a;  // Output stage
    logic [7:0]  m_dac_b;
    logic [1:0]  m_ovr_ev;
    logic [1:0]  m_ovr_q;  // Sticky status

    sdr_baseband_top u_sdr_baseband_top (
        .clk         (clk),
        .reset_i     (reset_i),
        .apb_req_i   (apb_req),
        .prdata_o    (prdata),
        .adc_a_i     (adc_a),
        .adc_b_i     (adc_b),
        .dac_a_o     (dac_a),
        .dac_b_o     (dac_b),
        .adc_ioexp_o (adc_ioexp),
        .dac_ioexp_o (dac_ioexp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 ns period

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= LIMIT) begin
            $display("Timeout: test sequence still running after %0d cycles", LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////
    // Random source
    //////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois form with taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q); // One step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Page in [15:12] with a random offset below
    function automatic logic [31:0] page_addr(input logic [3:0] page);
        logic [31:0] low;
        low = rand_bits(12);
        return {16'h0000, page, low[11:0]};
    endfunction

    function automatic logic [3:0] rand_unused_page();
        logic [3:0] p;
        p = 4'(rand_bits(4));
        while (p == 4'h0 || p == 4'h2 || p == 4'h3 || p == 4'h5) begin
            p = 4'(rand_bits(4));
        end
        return p;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic sample_t to_sample(input logic [7:0] raw);
        return sample_t'(int'(raw) - 128); // Offset binary with zero at 128
    endfunction

    function automatic sample_t tri_model(input logic [31:0] ph);
        int r;
        r = int'(ph[30:23]);
        if (ph[31]) begin
            r = 255 - r; // Falling half
        end
        return sample_t'(r - 128);
    endfunction

    function automatic logic [7:0] dac_model(input dac_cfg_u cfg);
        int s;
        case (cfg.fld.src)
            SRC_INA: s = m_st_a;
            SRC_INB: s = m_st_b;
            SRC_DDS: s = m_st_dds;
            default: s = 0;
        endcase
        return 8'(s + 128);
    endfunction

    function automatic logic [31:0] read_model(input logic [3:0] page);
        case (page)
            `SDR_PAGE_ADC:  return {30'b0, m_ovr_q | m_ovr_ev};
            `SDR_PAGE_DACA: return m_cfg_a.word;
            `SDR_PAGE_DACB: return m_cfg_b.word;
            `SDR_PAGE_DDS:  return m_dds;
            default:        return '0;
        endcase
    endfunction

    // Active-low LEDs and attenuators with red forced on during overrange
    function automatic logic [15:0] adc_ioexp_model();
        logic [15:0] w;
        logic [1:0]  st;
        st       = m_ovr_q | m_ovr_ev;
        w        = '0;
        w[14:13] = ~{st[0] | m_cfg_a.fld.led[2], st[1] | m_cfg_b.fld.led[2]};
        w[11:8]  = ~({m_cfg_b.fld.led[1:0], m_cfg_a.fld.led[1:0]} & ~{st[1], st[1], st[0], st[0]});
        w[6:4]   = {m_cfg_a.fld.amp_en, ~m_cfg_a.fld.att};
        w[2:0]   = {m_cfg_b.fld.amp_en, ~m_cfg_b.fld.att};
        return w;
    endfunction

    function automatic logic [15:0] dac_ioexp_model();
        logic [15:0] w;
        w       = '0;
        w[15]   = ~m_cfg_a.fld.led[2];
        w[13]   = ~m_cfg_b.fld.led[2];
        w[11:8] = ~{m_cfg_a.fld.led[1:0], m_cfg_b.fld.led[0], m_cfg_b.fld.led[1]};
        w[7:5]  = {~m_cfg_b.fld.att[0], ~m_cfg_b.fld.att[1], m_cfg_b.fld.amp_en};
        w[2:0]  = {~m_cfg_a.fld.att[0], ~m_cfg_a.fld.att[1], m_cfg_a.fld.amp_en};
        return w;
    endfunction

    // One rising edge with the inputs held across it
    task automatic step_model();
        logic       wr;
        logic [3:0] page;
        logic [1:0] clr;
        wr   = apb_req.psel && apb_req.penable && apb_req.pwrite;
        page = apb_req.paddr[15:12];
        clr  = (wr && page == `SDR_PAGE_ADC) ? apb_req.pwdata[1:0] : 2'b00;
        m_dac_a  = dac_model(m_cfg_a); // Old config and old stage
        m_dac_b  = dac_model(m_cfg_b);
        m_st_a   = to_sample(adc_a.data);
        m_st_b   = to_sample(adc_b.data);
        m_st_dds = tri_model(m_phase);
        m_phase  = m_dds.en ? m_phase + 32'(m_dds.step) : '0;
        m_ovr_q  = (m_ovr_q & ~clr) | m_ovr_ev; // New event beats the clear
        m_ovr_ev = {adc_b.ovr, adc_a.ovr};
        if (wr && page == `SDR_PAGE_DACA) m_cfg_a.word = apb_req.pwdata;
        if (wr && page == `SDR_PAGE_DACB) m_cfg_b.word = apb_req.pwdata;
        if (wr && page == `SDR_PAGE_DDS)  m_dds = dds_cfg_t'(apb_req.pwdata);
        if (reset_i) begin
            {m_cfg_a, m_cfg_b, m_dds, m_phase, m_ovr_ev, m_ovr_q} = '0;
            m_dac_a = 8'd128;
            m_dac_b = 8'd128;
        end
    endtask

    task automatic cycle();
        @(negedge clk); // Outputs settled and inputs free to change
        step_model();
    endtask

    //////////////////////////////
    // Compare and bus tasks
    //////////////////////////////

    task automatic check_dac(input string name, input logic [`SDR_SAMPLE_W-1:0] exp,
                             input logic [`SDR_SAMPLE_W-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_prdata(input string name, input logic [`SDR_APB_W-1:0] exp,
                                input logic [`SDR_APB_W-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ioexp(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apb_write(input logic [3:0] page, input logic [31:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: page_addr(page), pwdata: data};
        cycle();
        apb_req.penable = 1'b1; // Write lands on the edge closing the access cycle
        cycle();
        apb_req = '0;
    endtask

    // Read data is stable from the start of the access cycle
    task automatic apb_read_check(input string name, input logic [3:0] page);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: page_addr(page), pwdata: '0};
        cycle();
        check_prdata(name, read_model(page), prdata);
        apb_req.penable = 1'b1;
        cycle();
        apb_req = '0;
    endtask

    task automatic start_test();
        t_err0 = err_cnt;
        t_chk0 = chk_cnt;
    endtask

    task automatic report(input string name);
        $display("%s finished: %0d checks, %0d errors",
                 name, chk_cnt - t_chk0, err_cnt - t_err0);
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset();
        start_test();
        cycle();
        check_dac("reset dac_a", 8'd128, dac_a);
        check_dac("reset dac_b", 8'd128, dac_b);
        check_ioexp("reset adc_ioexp", adc_ioexp_model(), adc_ioexp);
        check_ioexp("reset dac_ioexp", dac_ioexp_model(), dac_ioexp);
        for (int p = 0; p < 16; p++) begin
            apb_read_check("reset read", 4'(p)); // Every page against an all-zero model
        end
        report("reset");
    endtask

    task automatic test_readback();
        start_test();
        repeat (8) begin
            apb_write(`SDR_PAGE_DACA, rand_bits(32));
            apb_write(`SDR_PAGE_DACB, rand_bits(32));
            apb_write(`SDR_PAGE_DDS, rand_bits(32));
            apb_read_check("readback dac_a", `SDR_PAGE_DACA);
            apb_read_check("readback dac_b", `SDR_PAGE_DACB);
            apb_read_check("readback dds", `SDR_PAGE_DDS);
            apb_read_check("readback status", `SDR_PAGE_ADC);
            apb_read_check("readback unused", rand_unused_page());
        end
        report("readback");
    endtask

    task automatic test_samples();
        dac_cfg_u cfg;
        start_test();
        for (int seg = 0; seg < 4; seg++) begin
            cfg.word    = rand_bits(32);
            cfg.fld.src = src_sel_t'(seg[1:0]); // DAC A walks all sources
            apb_write(`SDR_PAGE_DACA, cfg.word);
            apb_write(`SDR_PAGE_DACB, rand_bits(32));
            repeat (50) begin
                adc_a.data = 8'(rand_bits(8));
                adc_b.data = 8'(rand_bits(8));
                cycle();
                check_dac("samples dac_a", m_dac_a, dac_a);
                check_dac("samples dac_b", m_dac_b, dac_b);
            end
        end
        report("samples");
    endtask

    task automatic test_overrange();
        start_test();
        repeat (24) begin
            adc_a.ovr = 1'(rand_bits(1));
            adc_b.ovr = 1'(rand_bits(1));
            cycle();
            adc_a.ovr = 1'b0;
            adc_b.ovr = 1'b0;
            check_ioexp("overrange adc_ioexp", adc_ioexp_model(), adc_ioexp);
            apb_read_check("overrange status", `SDR_PAGE_ADC);
            // Random clear mask racing an occasional fresh event
            adc_a.ovr = 1'(rand_bits(1) & rand_bits(1));
            adc_b.ovr = 1'(rand_bits(1) & rand_bits(1));
            apb_write(`SDR_PAGE_ADC, rand_bits(32));
            adc_a.ovr = 1'b0;
            adc_b.ovr = 1'b0;
            check_ioexp("clear adc_ioexp", adc_ioexp_model(), adc_ioexp);
            check_ioexp("clear dac_ioexp", dac_ioexp_model(), dac_ioexp);
            apb_read_check("clear status", `SDR_PAGE_ADC);
        end
        report("overrange");
    endtask

    task automatic test_dds();
        dds_cfg_t dcfg;
        dac_cfg_u cfg;
        start_test();
        dcfg.en   = 1'b1;
        dcfg.step = 31'(rand_bits(28));
        apb_write(`SDR_PAGE_DDS, dcfg);
        cfg.word    = rand_bits(32);
        cfg.fld.src = SRC_DDS;
        apb_write(`SDR_PAGE_DACB, cfg.word);
        repeat (100) begin
            adc_a.data = 8'(rand_bits(8));
            adc_b.data = 8'(rand_bits(8));
            cycle();
            check_dac("dds dac_b", m_dac_b, dac_b);
            check_dac("dds dac_a", m_dac_a, dac_a);
        end
        apb_write(`SDR_PAGE_DDS, 32'h0);
        repeat (4) cycle(); // Phase clear then capture then mux
        check_dac("dds off", 8'(int'(tri_model(32'h0)) + 128), dac_b);
        report("dds");
    endtask

    initial begin
        lfsr_q  = 32'd10;
        reset_i = 1'b1;
        apb_req = '0;
        adc_a   = '{data: 8'h80, ovr: 1'b0};
        adc_b   = '{data: 8'h80, ovr: 1'b0};
        {m_cfg_a, m_cfg_b, m_dds, m_phase, m_ovr_ev, m_ovr_q} = '0;
        {m_st_a, m_st_b, m_st_dds, m_dac_a, m_dac_b} = '0;
        repeat (RESET_CYC) cycle();
        reset_i = 1'b0;
        test_reset();
        test_readback();
        test_samples();
        test_overrange();
        test_dds();
        $display("Summary: %0d checks passed, %0d errors, %0d assertion failures",
                 chk_cnt - err_cnt, err_cnt, u_sdr_baseband_top.u_sdr_baseband_chk.fail_cnt);
        if (err_cnt == 0 && u_sdr_baseband_top.u_sdr_baseband_chk.fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
